// ==== Makefile ====
# Verilator build and run of the processor testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_top \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/cpu_tests.txt ====
# test <name> opens a test, i <word> is the next instruction word in hex
# m <addr> <data> presets data memory, e <addr> <data> is the next expected store
test move_imm_reg
i 1205
i 15FD
i 0601
i 18FF
i B210
i B411
i B612
i B813
e 0010 0005
e 0011 FFFD
e 0012 0005
e 0013 00FF
test add_sub_wrap
i 12FF
i 15FF
i 5402
i 4601
i 7801
i 6202
i B420
i B621
i B822
i B223
e 0020 0001
e 0021 00FF
e 0022 FFFF
e 0023 00FE
test dependent_chain
i 1207
i 5203
i 4401
i 7401
i 4202
i 1C32
i B230
i B431
i A206
e 0030 0013
e 0031 0009
e 0032 0013
test load_store
m 0040 1234
m 0041 ABCD
i 9240
i 5201
i B250
i 1441
i 8602
i 1851
i A604
i 9A50
i 6A03
i BA52
e 0050 1235
e 0051 ABCD
e 0052 6668
test unused_opcodes
i 122A
i 3255
i D211
i E201
i 0000
i B260
e 0060 002A

// ==== dv/tb_checker.sv ====
//********************************************************************
// testbench checker: store scoreboard against the expected list
// reset behavior checks, per-test result lines and closing counts
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module tb_checker (
    input  wire                         Clock,
    input  wire                         Reset,
    input  wire  [`CPU_WORD_W-1:0]      instr_addr,
    input  wire  cpu_pkg::mem_req_t     data_req,
    input  wire                         data_done,
    output int                          error_count
);

    logic [`CPU_WORD_W-1:0] exp_addr [$];
    logic [`CPU_WORD_W-1:0] exp_data [$];
    int                     test_errors;
    int                     store_count;
    int                     cycles;         // rising edges since reset released
    int                     first_mem;      // program index of the first load or store
    int                     tests_passed;
    int                     tests_failed;

    initial begin
        error_count  = 0;
        test_errors  = 0;
        store_count  = 0;
        cycles       = 0;
        first_mem    = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

    task automatic note_error();
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(input int first_mem_index);
        exp_addr.delete();
        exp_data.delete();
        test_errors = 0;
        store_count = 0;
        first_mem   = first_mem_index;
    endtask

    task automatic expect_store(input logic [`CPU_WORD_W-1:0] addr,
                                input logic [`CPU_WORD_W-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // stores must come out in program order
    task automatic check_store(input logic [`CPU_WORD_W-1:0] addr,
                               input logic [`CPU_WORD_W-1:0] data);
        logic [`CPU_WORD_W-1:0] want_addr;
        logic [`CPU_WORD_W-1:0] want_data;
        store_count++;
        if (exp_addr.size() == 0) begin
            $display("unexpected extra store of %h to address %h", data, addr);
            note_error();
        end else begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            if (addr !== want_addr) begin
                $display("MISMATCH data_req.addr: got %h expected %h", addr, want_addr);
                note_error();
            end
            if (data !== want_data) begin
                $display("MISMATCH data_req.wdata: got %h expected %h", data, want_data);
                note_error();
            end
        end
    endtask

    always @(posedge Clock) begin
        if (Reset) begin
            cycles = 0;
        end else begin
            if (cycles == 0 && instr_addr !== '0) begin
                $display("MISMATCH instr_addr: got %h expected %h", instr_addr, 16'h0000);
                note_error();
            end
            // first load or store reaches the memory stage three edges after its fetch
            if ((data_req.read || data_req.write) && cycles < first_mem + 3) begin
                $display("data request made %0d cycles after reset, before any load or store",
                         cycles);
                note_error();
            end
            if (data_done && data_req.write) begin
                check_store(data_req.addr, data_req.wdata);
            end
            cycles++;
        end
    end

    task automatic finish_test(input logic [8*24-1:0] name);
        while (exp_addr.size() > 0) begin
            $display("expected store of %h to address %h never happened",
                     exp_data[0], exp_addr[0]);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            note_error();
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0s: passed, %0d stores", name, store_count);
        end else begin
            tests_failed++;
            $display("test %0s: failed, %0d errors", name, test_errors);
        end
    endtask

    task automatic report();
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    endtask

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
//********************************************************************
// processor testbench top: clock, reset, test file reader
// instruction and data memory models with LFSR wait states
// run watchdog, final result
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module tb_top;

    localparam int MAX_TESTS = 16;
    localparam int MAX_ITEMS = 256;

    logic                   Clock;
    logic                   Reset;
    logic [`CPU_WORD_W-1:0] instr_in;
    logic [`CPU_WORD_W-1:0] instr_addr;
    logic [`CPU_WORD_W-1:0] data_in;
    logic                   data_done;
    cpu_pkg::mem_req_t      data_req;
    int                     error_count;

    // tests as read from the file, pairs packed as {addr, data}
    logic [8*24-1:0]        test_name [MAX_TESTS];
    int                     instr_first [MAX_TESTS];
    int                     instr_num [MAX_TESTS];
    int                     mem_first [MAX_TESTS];
    int                     mem_num [MAX_TESTS];
    int                     exp_first [MAX_TESTS];
    int                     exp_num [MAX_TESTS];
    logic [`CPU_WORD_W-1:0] instr_word [MAX_ITEMS];
    logic [31:0]            mem_pair [MAX_ITEMS];
    logic [31:0]            exp_pair [MAX_ITEMS];
    int                     num_tests;
    int                     num_instr;
    int                     num_mem;
    int                     num_exp;

    logic [`CPU_WORD_W-1:0] imem [256];
    logic [`CPU_WORD_W-1:0] dmem [65536];
    int                     prog_len;
    int                     limit_cycles;
    logic [15:0]            lfsr;
    logic [1:0]             wait_left;      // wait cycles left for the current access
    logic                   req_seen;

    cpu_top i_dut (
        .Clock      (Clock),
        .Reset      (Reset),
        .instr_in   (instr_in),
        .instr_addr (instr_addr),
        .data_in    (data_in),
        .data_done  (data_done),
        .data_req   (data_req)
    );

    tb_checker i_checker (
        .Clock       (Clock),
        .Reset       (Reset),
        .instr_addr  (instr_addr),
        .data_req    (data_req),
        .data_done   (data_done),
        .error_count (error_count)
    );

    always #2 Clock = ~Clock;

    // past the end of the program the fetch sees zero, a nop
    assign instr_in = (instr_addr < prog_len) ? imem[instr_addr[7:0]] : '0;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [`CPU_WORD_W-1:0] fill_word(input logic [`CPU_WORD_W-1:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'h5a3c;
    endfunction

    // loads and stores, told apart by the opcode field alone
    function automatic logic is_mem_instr(input logic [`CPU_WORD_W-1:0] word);
        return word[`CPU_OP_MSB:`CPU_OP_LSB] == `CPU_OP_LD ||
               word[`CPU_OP_MSB:`CPU_OP_LSB] == `CPU_OP_ST;
    endfunction

    // data port model, driven on the falling edge
    always @(negedge Clock) begin
        if (Reset) begin
            data_done = 1'b0;
            req_seen  = 1'b0;
        end else begin
            if (data_done) begin
                data_done = 1'b0;           // access ended at the last rising edge
                req_seen  = 1'b0;
            end
            if (data_req.read || data_req.write) begin
                if (!req_seen) begin
                    req_seen     = 1'b1;
                    lfsr         = lfsr_next(lfsr);
                    wait_left[1] = lfsr[0];
                    lfsr         = lfsr_next(lfsr);
                    wait_left[0] = lfsr[0];
                end
                if (wait_left == 2'd0) begin
                    data_done = 1'b1;
                    if (data_req.write) begin
                        dmem[data_req.addr] = data_req.wdata;
                    end else begin
                        data_in = dmem[data_req.addr];
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    task automatic read_tests(output logic ok);
        int                     fd;
        int                     code;
        logic [8*16-1:0]        tag;
        logic [8*80-1:0]        rest;
        logic [8*24-1:0]        name;
        logic [`CPU_WORD_W-1:0] addr;
        logic [`CPU_WORD_W-1:0] data;
        ok        = 1'b1;
        num_tests = 0;
        num_instr = 0;
        num_mem   = 0;
        num_exp   = 0;
        fd = $fopen("dv/cpu_tests.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "test": begin
                        code = $fscanf(fd, "%s", name);
                        test_name[num_tests]   = name;
                        instr_first[num_tests] = num_instr;
                        mem_first[num_tests]   = num_mem;
                        exp_first[num_tests]   = num_exp;
                        instr_num[num_tests]   = 0;
                        mem_num[num_tests]     = 0;
                        exp_num[num_tests]     = 0;
                        num_tests++;
                    end
                    "i": begin
                        code = $fscanf(fd, "%h", data);
                        instr_word[num_instr] = data;
                        instr_num[num_tests-1]++;
                        num_instr++;
                    end
                    "m": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        mem_pair[num_mem] = {addr, data};
                        mem_num[num_tests-1]++;
                        num_mem++;
                    end
                    "e": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        exp_pair[num_exp] = {addr, data};
                        exp_num[num_tests-1]++;
                        num_exp++;
                    end
                    default: begin
                        $display("unknown line type %0s in the test file", tag);
                        ok = 1'b0;
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t);
        logic [31:0] pair;
        int          first_mem;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < instr_num[t]; i++) begin
            imem[i] = instr_word[instr_first[t] + i];
        end
        first_mem = instr_num[t];           // no load or store in the program
        for (int i = instr_num[t] - 1; i >= 0; i--) begin
            if (is_mem_instr(imem[i])) begin
                first_mem = i;
            end
        end
        for (int i = 0; i < 65536; i++) begin
            dmem[i] = fill_word(16'(i));
        end
        for (int i = 0; i < mem_num[t]; i++) begin
            pair = mem_pair[mem_first[t] + i];
            dmem[pair[31:16]] = pair[15:0];
        end
        i_checker.start_test(first_mem);
        for (int i = 0; i < exp_num[t]; i++) begin
            pair = exp_pair[exp_first[t] + i];
            i_checker.expect_store(pair[31:16], pair[15:0]);
        end
        prog_len = instr_num[t];
        repeat (8) @(posedge Clock);
        @(negedge Clock);
        Reset = 1'b0;
        // last instruction has left the memory stage four fetches later
        while (!(instr_addr >= prog_len + 5 && !data_req.read && !data_req.write)) begin
            @(negedge Clock);
        end
        i_checker.finish_test(test_name[t]);
        Reset = 1'b1;
    endtask

    initial begin
        logic ok;
        Clock        = 1'b0;
        Reset        = 1'b1;
        data_in      = '0;
        data_done    = 1'b0;
        lfsr         = 16'd56;
        wait_left    = 2'd0;
        req_seen     = 1'b0;
        prog_len     = 0;
        limit_cycles = 0;
        read_tests(ok);
        if (!ok) begin
            $display("test file dv/cpu_tests.txt could not be read");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            limit_cycles = 40 * num_instr + 16 * num_tests;
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            i_checker.report();
            if (error_count == 0 && num_tests > 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge Clock);
        $display("run did not finish within %0d cycles", limit_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/cpu_config.svh ====
//********************************************************************
// processor word and register file sizes
// instruction field positions and opcode values
//********************************************************************
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_WORD_W    16
`define CPU_NUM_REGS  8
`define CPU_REG_W     3
`define CPU_PC_REG    3'd7      // r7 is the program counter

// instruction word layout, imm9 sits below rx
`define CPU_OP_MSB    15
`define CPU_OP_LSB    13
`define CPU_IMM_BIT   12

`define CPU_OP_MV     3'b000
`define CPU_OP_ADD    3'b010
`define CPU_OP_SUB    3'b011
`define CPU_OP_LD     3'b100
`define CPU_OP_ST     3'b101

`endif

// ==== src.f ====
+incdir+include
src/cpu_pkg.sv
src/reg_file.sv
src/fetch_decode.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== src/cpu_pkg.sv ====
//********************************************************************
// shared processor types: instruction union, alu op encoding,
// stage payload, writeback and data memory request structs
//********************************************************************
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [1:0] {
        alu_nop,
        alu_mov,
        alu_add,
        alu_sub
    } alu_op_t;

    // III M XXX DDDDDDDDD
    typedef struct packed {
        logic [`CPU_OP_MSB-`CPU_OP_LSB:0]     opcode;
        logic                                 imm;
        logic [`CPU_REG_W-1:0]                rx;
        logic [`CPU_IMM_BIT-`CPU_REG_W-1:0]   imm9;     // sign extended in decode
    } instr_imm_t;

    // III M XXX 000000 YYY
    typedef struct packed {
        logic [`CPU_OP_MSB-`CPU_OP_LSB:0]     opcode;
        logic                                 imm;
        logic [`CPU_REG_W-1:0]                rx;
        logic [`CPU_IMM_BIT-2*`CPU_REG_W-1:0] pad;
        logic [`CPU_REG_W-1:0]                ry;
    } instr_reg_t;

    // the imm bit picks which view is meaningful
    typedef union packed {
        instr_imm_t imm_view;
        instr_reg_t reg_view;
    } instr_t;

    typedef struct packed {
        logic                   valid;
        alu_op_t                alu_op;
        logic [`CPU_REG_W-1:0]  rx;
        logic [`CPU_WORD_W-1:0] op1;        // value of rx, store data
        logic [`CPU_WORD_W-1:0] op2;        // ry or immediate, also the memory address
        logic [`CPU_WORD_W-1:0] result;
        logic                   read;
        logic                   write;
        logic                   writeback;
    } stage_op_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_REG_W-1:0]  rx;
        logic [`CPU_WORD_W-1:0] value;
    } wb_t;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`CPU_WORD_W-1:0] addr;
        logic [`CPU_WORD_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== src/cpu_top.sv ====
//********************************************************************
// processor top level
// connects fetch/decode, register file, execute and memory stages
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module cpu_top (
    input  wire                         Clock,
    input  wire                         Reset,
    input  wire  [`CPU_WORD_W-1:0]      instr_in,
    output logic [`CPU_WORD_W-1:0]      instr_addr,
    input  wire  [`CPU_WORD_W-1:0]      data_in,
    input  wire                         data_done,
    output cpu_pkg::mem_req_t           data_req
);

    logic [`CPU_REG_W-1:0]  rd_addr_a;
    logic [`CPU_REG_W-1:0]  rd_addr_b;
    logic [`CPU_WORD_W-1:0] rd_data_a;
    logic [`CPU_WORD_W-1:0] rd_data_b;
    cpu_pkg::stage_op_t     decode_op;
    cpu_pkg::stage_op_t     exec_op;
    cpu_pkg::stage_op_t     mem_op;
    cpu_pkg::wb_t           wb;
    logic                   busy;       // data access still waiting

    fetch_decode i_fetch_decode (
        .Clock      (Clock),
        .Reset      (Reset),
        .instr_in   (instr_in),
        .instr_addr (instr_addr),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .exec_op    (exec_op),
        .mem_op     (mem_op),
        .wb         (wb),
        .busy       (busy),
        .decode_op  (decode_op)
    );

    reg_file i_reg_file (
        .Clock      (Clock),
        .Reset      (Reset),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wb         (wb)
    );

    execute_stage i_execute_stage (
        .Clock      (Clock),
        .Reset      (Reset),
        .decode_op  (decode_op),
        .busy       (busy),
        .exec_op    (exec_op)
    );

    memory_stage i_memory_stage (
        .Clock      (Clock),
        .Reset      (Reset),
        .exec_op    (exec_op),
        .data_in    (data_in),
        .data_done  (data_done),
        .data_req   (data_req),
        .busy       (busy),
        .mem_op     (mem_op),
        .wb         (wb)
    );

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
//********************************************************************
// execute pipeline register
// move, add and subtract ALU
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module execute_stage (
    input  wire                         Clock,
    input  wire                         Reset,
    input  wire  cpu_pkg::stage_op_t    decode_op,
    input  wire                         busy,
    output cpu_pkg::stage_op_t          exec_op
);

    cpu_pkg::stage_op_t next_op;

    // result wraps at the word width
    always_comb begin
        next_op = decode_op;
        case (decode_op.alu_op)
            cpu_pkg::alu_mov: next_op.result = decode_op.op2;
            cpu_pkg::alu_add: next_op.result = decode_op.op1 + decode_op.op2;
            cpu_pkg::alu_sub: next_op.result = decode_op.op1 - decode_op.op2;
            default:          next_op.result = '0;      // loads and stores fill it later
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            exec_op <= '0;
        end else if (!busy) begin
            exec_op <= next_op;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_decode.sv ====
//********************************************************************
// program counter and instruction fetch register
// decode into the stage payload, operand read
// read-after-write interlock against execute, memory and writeback
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module fetch_decode (
    input  wire                         Clock,
    input  wire                         Reset,
    input  wire  [`CPU_WORD_W-1:0]      instr_in,
    output logic [`CPU_WORD_W-1:0]      instr_addr,
    output logic [`CPU_REG_W-1:0]       rd_addr_a,
    output logic [`CPU_REG_W-1:0]       rd_addr_b,
    input  wire  [`CPU_WORD_W-1:0]      rd_data_a,
    input  wire  [`CPU_WORD_W-1:0]      rd_data_b,
    input  wire  cpu_pkg::stage_op_t    exec_op,
    input  wire  cpu_pkg::stage_op_t    mem_op,
    input  wire  cpu_pkg::wb_t          wb,
    input  wire                         busy,
    output cpu_pkg::stage_op_t          decode_op
);

    logic [`CPU_WORD_W-1:0] pc;
    logic [`CPU_WORD_W-1:0] fetch_word;
    cpu_pkg::instr_t        instr;
    cpu_pkg::stage_op_t     dec;
    logic                   hazard;
    logic                   stall;

    // true when some instruction still in flight will write register r
    function automatic logic pending_write(input logic [`CPU_REG_W-1:0] r);
        return (exec_op.valid && exec_op.writeback && exec_op.rx == r) ||
               (mem_op.valid && mem_op.writeback && mem_op.rx == r) ||
               (wb.valid && wb.rx == r);
    endfunction

    assign instr_addr = pc;
    assign instr      = fetch_word;
    assign rd_addr_a  = instr.imm_view.rx;
    assign rd_addr_b  = instr.reg_view.ry;

    always_comb begin
        dec     = '0;
        dec.rx  = instr.imm_view.rx;
        dec.op1 = (instr.imm_view.rx == `CPU_PC_REG) ? pc : rd_data_a;   // r7 reads the fetch address
        if (instr.imm_view.imm) begin
            dec.op2 = {{(`CPU_WORD_W-$bits(instr.imm_view.imm9)){instr.imm_view.imm9[8]}},
                       instr.imm_view.imm9};
        end else begin
            dec.op2 = (instr.reg_view.ry == `CPU_PC_REG) ? pc : rd_data_b;
        end
        case (instr.imm_view.opcode)
            `CPU_OP_MV: begin
                dec.valid  = 1'b1;
                dec.alu_op = cpu_pkg::alu_mov;
            end
            `CPU_OP_ADD: begin
                dec.valid  = 1'b1;
                dec.alu_op = cpu_pkg::alu_add;
            end
            `CPU_OP_SUB: begin
                dec.valid  = 1'b1;
                dec.alu_op = cpu_pkg::alu_sub;
            end
            `CPU_OP_LD: begin
                dec.valid = 1'b1;
                dec.read  = 1'b1;
            end
            `CPU_OP_ST: begin
                dec.valid = 1'b1;
                dec.write = 1'b1;
            end
            default: dec.valid = 1'b0;      // 001, 110, 111 are nops
        endcase
        if (fetch_word == '0) begin
            dec.valid = 1'b0;               // all-zero word is a nop too
        end
        // stores have nothing to write back, and r7 is never a destination
        dec.writeback = dec.valid && !dec.write && (dec.rx != `CPU_PC_REG);
    end

    // ry only matters in the register view
    always_comb begin
        hazard = 1'b0;
        if (dec.valid) begin
            hazard = pending_write(instr.imm_view.rx) ||
                     (!instr.imm_view.imm && pending_write(instr.reg_view.ry));
        end
    end

    assign stall     = busy || hazard;
    assign decode_op = hazard ? '0 : dec;   // bubble into execute

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc         <= '0;
            fetch_word <= '0;
        end else if (!stall) begin
            pc         <= pc + 1'b1;
            fetch_word <= instr_in;
        end
    end

    decode_rw_excl: assert property (@(posedge Clock) disable iff (Reset)
        !(decode_op.read && decode_op.write));

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
//********************************************************************
// memory and writeback pipeline registers
// data port request held until data_done, load data capture
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module memory_stage (
    input  wire                         Clock,
    input  wire                         Reset,
    input  wire  cpu_pkg::stage_op_t    exec_op,
    input  wire  [`CPU_WORD_W-1:0]      data_in,
    input  wire                         data_done,
    output cpu_pkg::mem_req_t           data_req,
    output logic                        busy,
    output cpu_pkg::stage_op_t          mem_op,
    output cpu_pkg::wb_t                wb
);

    logic mem_active;

    assign mem_active = mem_op.valid && (mem_op.read || mem_op.write);
    assign busy       = mem_active && !data_done;   // stalls the whole pipe

    // request comes straight from the registered payload, so it holds while busy
    always_comb begin
        data_req.read  = mem_active && mem_op.read;
        data_req.write = mem_active && mem_op.write;
        data_req.addr  = mem_op.op2;
        data_req.wdata = mem_op.op1;
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mem_op <= '0;
        end else if (!busy) begin
            mem_op <= exec_op;
        end
    end

    // a waiting access sends bubbles into writeback
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            wb <= '0;
        end else if (busy) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= mem_op.valid && mem_op.writeback;
            wb.rx    <= mem_op.rx;
            wb.value <= mem_op.read ? data_in : mem_op.result;
        end
    end

    req_stable: assert property (@(posedge Clock) disable iff (Reset)
        busy |=> $stable(data_req));

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
//********************************************************************
// general register file, eight entries
// two combinational read ports, one write port fed by writeback
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module reg_file (
    input  wire                         Clock,
    input  wire                         Reset,
    input  wire  [`CPU_REG_W-1:0]       rd_addr_a,
    input  wire  [`CPU_REG_W-1:0]       rd_addr_b,
    output logic [`CPU_WORD_W-1:0]      rd_data_a,
    output logic [`CPU_WORD_W-1:0]      rd_data_b,
    input  wire  cpu_pkg::wb_t          wb
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rx] <= wb.value;
        end
    end

    // no write-to-read bypass, decode interlocks on the writeback stage instead
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // the PC lives in fetch, decode never lets a result target it
    no_pc_write: assert property (@(posedge Clock) disable iff (Reset)
        wb.valid |-> wb.rx != `CPU_PC_REG);

endmodule

`default_nettype wire
